/* logic/core_types_pkg.sv */
// Core-wide types sized for a four-thread core; thread_idx_t width follows THREADS_PER_CORE
package core_types_pkg;

	// Number of hardware threads in one core
	localparam int THREADS_PER_CORE = 4;

	// Width of a data word on the register path
	localparam int SCALAR_WIDTH = 32;

	// Width of the core number field
	localparam int CORE_ID_WIDTH = 4;

	// Bits needed to name one thread
	localparam int THREAD_IDX_WIDTH = $clog2(THREADS_PER_CORE);

	// A thread number, 0 up to THREADS_PER_CORE - 1
	typedef logic [THREAD_IDX_WIDTH - 1:0] thread_idx_t;

	// One bit per thread, bit n belongs to thread n
	typedef logic [THREADS_PER_CORE - 1:0] thread_mask_t;

	// A data word as read from or written to a control register
	typedef logic [SCALAR_WIDTH - 1:0] scalar_t;

	// The number of this core within a larger system
	typedef logic [CORE_ID_WIDTH - 1:0] core_id_t;

endpackage

/* logic/creg_defs_pkg.sv */
// Control register map and fault encodings; indices beyond CR_INTERRUPT_ENABLE are unused
package creg_defs_pkg;

	import core_types_pkg::*;

	// Register index as it arrives from the data stage
	typedef enum logic [4:0]
	{
		CR_THREAD_ENABLE = 5'd0,
		CR_THREAD_ID = 5'd1,
		CR_HALT_THREAD = 5'd2,
		CR_HALT = 5'd3,
		CR_FAULT_PC = 5'd4,
		CR_FAULT_REASON = 5'd5,
		CR_INTERRUPT_ENABLE = 5'd6
	} control_register_t;

	// Cause stored with a fault, FR_NONE means no fault seen yet
	typedef enum logic [2:0]
	{
		FR_NONE = 3'd0,
		FR_ILLEGAL_INSTR = 3'd1,
		FR_ACCESS_VIOLATION = 3'd2,
		FR_UNALIGNED = 3'd3
	} fault_reason_t;

	// Raw flags from writeback, more than one may be set at once
	typedef struct packed
	{
		logic illegal_instr;
		logic access_violation;
		logic unaligned;
		scalar_t pc;
		thread_idx_t thread;
		// Kept at zero by the producer
		logic [2:0] spare;
	} fault_flags_t;

	// One fault after prioritization
	typedef struct packed
	{
		logic valid;
		fault_reason_t reason;
		scalar_t pc;
		thread_idx_t thread;
	} fault_report_t;

	// A single control register access, strobes are active high
	typedef struct packed
	{
		logic write_en;
		logic read_en;
		control_register_t index;
		scalar_t write_val;
	} creg_access_t;

	// Payload of the request stage, the access with its issuing thread
	typedef struct packed
	{
		creg_access_t access;
		thread_idx_t thread;
	} creg_req_stage_t;

	// Travels beside the read value so a response knows its thread
	typedef struct packed
	{
		logic read;
		thread_idx_t thread;
	} creg_resp_tag_t;

endpackage

/* logic/pipe_stage.sv */
// One-cycle register stage; only the valid bit is reset, the payload is undefined until first load
`timescale 1ns/10ps

module pipe_stage
	#(parameter type payload_t = logic)
	(
	input clk,
	input reset,
	input logic in_valid,
	input payload_t in_data,
	output logic out_valid,
	output payload_t out_data
	);

	// Valid is control state and must come out of reset low
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	// Payload follows the input on every edge
	// Consumers look at it only while out_valid is high
	always_ff @(posedge clk)
	begin
		out_data <= in_data;
	end

endmodule

/* logic/thread_select.sv */
// Round-robin thread picker; the selection moves one thread per unstalled edge, never two
`timescale 1ns/10ps

module thread_select
	import core_types_pkg::*;
	(
	input clk,
	input reset,
	input thread_mask_t thread_enable,
	input logic stall,
	output thread_idx_t issue_thread,
	output logic issue_valid
	);

	thread_idx_t next_thread;
	thread_idx_t candidate;
	logic found;

	// Anything enabled means there is a thread to issue
	assign issue_valid = |thread_enable;

	// Look forward from the current thread for the next enabled one
	// The offset runs up to the full thread count so the current thread is
	// checked last, which lets a single enabled thread keep issuing
	always_comb
	begin
		next_thread = issue_thread;
		candidate = issue_thread;
		found = 1'b0;
		for (int i = 1; i <= THREADS_PER_CORE; i++)
		begin
			candidate = issue_thread + thread_idx_t'(i);
			if (!found && thread_enable[candidate])
			begin
				next_thread = candidate;
				found = 1'b1;
			end
		end
	end

	// Hold on stall, and also hold when nothing is enabled
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			issue_thread <= '0;
		else if (!stall && found)
			issue_thread <= next_thread;
	end

endmodule

/* logic/fault_encoder.sv */
// Fault prioritizer with one cycle of latency; a second fault in the next cycle overwrites the first
`timescale 1ns/10ps

module fault_encoder
	import core_types_pkg::*;
	import creg_defs_pkg::*;
	(
	input clk,
	input reset,
	input fault_flags_t fault_flags,
	output fault_report_t fault_report
	);

	logic any_fault;
	fault_reason_t reason;
	logic report_valid;
	fault_reason_t report_reason;
	scalar_t report_pc;
	thread_idx_t report_thread;

	assign any_fault = fault_flags.illegal_instr || fault_flags.access_violation
		|| fault_flags.unaligned;

	// Illegal instruction beats access violation, which beats unaligned
	always_comb
	begin
		if (fault_flags.illegal_instr)
			reason = FR_ILLEGAL_INSTR;
		else if (fault_flags.access_violation)
			reason = FR_ACCESS_VIOLATION;
		else if (fault_flags.unaligned)
			reason = FR_UNALIGNED;
		else
			reason = FR_NONE;
	end

	// The report is valid for exactly the cycle after a flagged one
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			report_valid <= 1'b0;
		else
			report_valid <= any_fault;
	end

	// Details are captured only when something was flagged
	always_ff @(posedge clk)
	begin
		if (any_fault)
		begin
			report_reason <= reason;
			report_pc <= fault_flags.pc;
			report_thread <= fault_flags.thread;
		end
	end

	assign fault_report = '{valid: report_valid, reason: report_reason, pc: report_pc,
		thread: report_thread};

endmodule

/* logic/control_registers.sv */
// Control registers fed from the data stage; write beats read, unknown indices read as 0
`timescale 1ns/10ps

module control_registers
	import core_types_pkg::*;
	import creg_defs_pkg::*;
	#(parameter core_id_t CORE_ID = '0)
	(
	input clk,
	input reset,

	// Prioritized fault from the encoder
	input fault_report_t fault_report,

	// Data stage access, unregistered strobes with the thread in that stage
	input creg_access_t access,
	input logic access_valid,
	input thread_idx_t access_thread,

	// Register contents that steer the rest of the core
	output thread_mask_t thread_enable,
	output thread_mask_t interrupt_en,

	// Registered result of the last read
	output scalar_t read_value
	);

	scalar_t fault_pc[THREADS_PER_CORE];
	fault_reason_t fault_reason[THREADS_PER_CORE];
	logic do_write;
	logic do_read;

	// A write in the same access suppresses the read
	assign do_write = access_valid && access.write_en;
	assign do_read = access_valid && access.read_en && !access.write_en;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			// Only thread 0 runs out of reset
			thread_enable <= thread_mask_t'(1);
			interrupt_en <= '0;
			for (int i = 0; i < THREADS_PER_CORE; i++)
			begin
				fault_reason[i] <= FR_NONE;
				fault_pc[i] <= '0;
			end
		end
		else
		begin
			// Record the fault and mask interrupts for the faulting thread
			if (fault_report.valid)
			begin
				fault_reason[fault_report.thread] <= fault_report.reason;
				fault_pc[fault_report.thread] <= fault_report.pc;
				interrupt_en[fault_report.thread] <= 1'b0;
			end

			// Comes after the fault update so an interrupt enable write to the
			// same thread in the same cycle takes effect
			if (do_write)
			begin
				case (access.index)
					CR_THREAD_ENABLE:
						thread_enable <= access.write_val[THREADS_PER_CORE - 1:0];
					CR_HALT_THREAD:
						thread_enable[access_thread] <= 1'b0;
					CR_INTERRUPT_ENABLE:
						interrupt_en[access_thread] <= 1'b1;
					CR_HALT:
						thread_enable <= '0;
					default:
						;
				endcase
			end
		end
	end

	// Read data lands on the same edge as the response tag
	always_ff @(posedge clk)
	begin
		if (do_read)
		begin
			case (access.index)
				// Core number above the thread number, so core * threads + thread
				CR_THREAD_ID:
					read_value <= scalar_t'({CORE_ID, access_thread});
				CR_FAULT_PC:
					read_value <= fault_pc[access_thread];
				CR_FAULT_REASON:
					read_value <= scalar_t'(fault_reason[access_thread]);
				default:
					read_value <= '0;
			endcase
		end
	end

endmodule

/* logic/creg_subsystem.sv */
// Subsystem top; an access takes issue_thread and is dropped while issue_valid is low
`timescale 1ns/10ps

module creg_subsystem
	import core_types_pkg::*;
	import creg_defs_pkg::*;
	#(parameter core_id_t CORE_ID = '0)
	(
	input clk,
	input reset,
	input creg_access_t creg_access,
	input logic stall,
	input fault_flags_t fault_flags,
	output thread_idx_t issue_thread,
	output logic issue_valid,
	output thread_mask_t thread_enable,
	output thread_mask_t interrupt_en,
	output logic resp_valid,
	output thread_idx_t resp_thread,
	output scalar_t resp_value
	);

	logic req_in_valid;
	creg_req_stage_t req_in;
	logic req_valid;
	creg_req_stage_t req_stage;
	creg_resp_tag_t resp_tag_in;
	logic resp_stage_valid;
	creg_resp_tag_t resp_tag;
	fault_report_t fault_report;
	scalar_t read_value;

	thread_select i_thread_select(
		.clk(clk),
		.reset(reset),
		.thread_enable(thread_enable),
		.stall(stall),
		.issue_thread(issue_thread),
		.issue_valid(issue_valid));

	// An access enters the request stage only with a live thread and a strobe
	assign req_in_valid = issue_valid && (creg_access.write_en || creg_access.read_en);
	assign req_in = '{access: creg_access, thread: issue_thread};

	pipe_stage #(.payload_t(creg_req_stage_t)) i_req_stage(
		.clk(clk),
		.reset(reset),
		.in_valid(req_in_valid),
		.in_data(req_in),
		.out_valid(req_valid),
		.out_data(req_stage));

	fault_encoder i_fault_encoder(
		.clk(clk),
		.reset(reset),
		.fault_flags(fault_flags),
		.fault_report(fault_report));

	control_registers #(.CORE_ID(CORE_ID)) i_control_registers(
		.clk(clk),
		.reset(reset),
		.fault_report(fault_report),
		.access(req_stage.access),
		.access_valid(req_valid),
		.access_thread(req_stage.thread),
		.thread_enable(thread_enable),
		.interrupt_en(interrupt_en),
		.read_value(read_value));

	// Mirrors the read decision in control_registers, a write masks the read
	assign resp_tag_in = '{read: req_stage.access.read_en && !req_stage.access.write_en,
		thread: req_stage.thread};

	pipe_stage #(.payload_t(creg_resp_tag_t)) i_resp_stage(
		.clk(clk),
		.reset(reset),
		.in_valid(req_valid),
		.in_data(resp_tag_in),
		.out_valid(resp_stage_valid),
		.out_data(resp_tag));

	// Tag and value were registered on the same edge and line up here
	assign resp_valid = resp_stage_valid && resp_tag.read;
	assign resp_thread = resp_tag.thread;
	assign resp_value = read_value;

endmodule

/* test/creg_subsystem_tb.sv */
// Directed tests with CORE_ID 5; stall stays high between tests so each access has a known thread
`timescale 1ns/10ps

module creg_subsystem_tb
	import core_types_pkg::*;
	import creg_defs_pkg::*;
	();

	localparam core_id_t TB_CORE_ID = 4'd5;
	localparam logic [16:0] LFSR_SEED = 17'd67669;
	localparam int RESP_TIMEOUT = 16;
	localparam int SILENT_WINDOW = 12;
	localparam int STEER_LIMIT = 2 * THREADS_PER_CORE;
	localparam int WATCHDOG_CYCLES = 20000;

	logic clk;
	logic reset;
	creg_access_t creg_access;
	logic stall;
	fault_flags_t fault_flags;
	thread_idx_t issue_thread;
	logic issue_valid;
	thread_mask_t thread_enable;
	thread_mask_t interrupt_en;
	logic resp_valid;
	thread_idx_t resp_thread;
	scalar_t resp_value;
	logic [16:0] lfsr_state;

	creg_subsystem #(.CORE_ID(TB_CORE_ID)) i_creg_subsystem(
		.clk(clk),
		.reset(reset),
		.creg_access(creg_access),
		.stall(stall),
		.fault_flags(fault_flags),
		.issue_thread(issue_thread),
		.issue_valid(issue_valid),
		.thread_enable(thread_enable),
		.interrupt_en(interrupt_en),
		.resp_valid(resp_valid),
		.resp_thread(resp_thread),
		.resp_value(resp_value));

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic expect_equal(input string name, input scalar_t actual, input scalar_t expected);
		assert (actual === expected)
		else
			abort_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected));
	endtask

	// 17-bit Fibonacci LFSR, taps at bits 17 and 14
	function automatic logic [16:0] lfsr_next(input logic [16:0] state);
		return {state[15:0], state[16] ^ state[13]};
	endfunction

	// One LFSR step per bit taken, newest bit lands in the LSB
	task automatic draw_bits(input int count, output scalar_t bits);
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
	endtask

	// Round-robin rule: the nearest enabled thread after the current one, wrapping around
	// Scanning from the far end leaves the nearest match in result
	function automatic thread_idx_t next_enabled(input thread_idx_t current,
		input thread_mask_t mask);
		thread_idx_t result;
		int probe;
		result = current;
		for (int i = THREADS_PER_CORE; i >= 1; i--)
		begin
			probe = (int'(current) + i) % THREADS_PER_CORE;
			if (mask[probe])
				result = thread_idx_t'(probe);
		end
		return result;
	endfunction

	// Illegal instruction outranks access violation, which outranks unaligned
	function automatic fault_reason_t expected_reason(input logic illegal, input logic violation,
		input logic unaligned_access);
		if (illegal)
			return FR_ILLEGAL_INSTR;
		if (violation)
			return FR_ACCESS_VIOLATION;
		if (unaligned_access)
			return FR_UNALIGNED;
		return FR_NONE;
	endfunction

	// Drop stall for exactly one edge so issue_thread advances once
	task automatic step_thread();
		@(posedge clk) stall <= 1'b0;
		@(posedge clk) stall <= 1'b1;
		@(negedge clk);
	endtask

	task automatic steer_to_thread(input thread_idx_t target);
		int tries;
		tries = 0;
		@(negedge clk);
		while (issue_thread !== target && tries < STEER_LIMIT)
		begin
			step_thread();
			tries++;
		end
		assert (issue_thread === target)
		else
			abort_run($sformatf("issue_thread never reached thread %0d", target));
	endtask

	// Returns after the edge on which the registers took the write
	task automatic write_creg(input control_register_t reg_index, input scalar_t value);
		creg_access_t access;
		access = '{write_en: 1'b1, read_en: 1'b0, index: reg_index, write_val: value};
		@(posedge clk) creg_access <= access;
		@(posedge clk) creg_access <= '0;
		@(posedge clk);
		@(negedge clk);
	endtask

	// Latency counts edges from the one that samples the access to the response
	task automatic read_creg(input control_register_t reg_index, output scalar_t value,
		output thread_idx_t thread, output int latency);
		creg_access_t access;
		logic got;
		access = '{write_en: 1'b0, read_en: 1'b1, index: reg_index, write_val: '0};
		got = 1'b0;
		latency = 0;
		value = '0;
		thread = '0;
		@(posedge clk) creg_access <= access;
		while (!got && latency < RESP_TIMEOUT)
		begin
			@(posedge clk) creg_access <= '0;
			latency++;
			@(negedge clk);
			if (resp_valid === 1'b1)
			begin
				got = 1'b1;
				value = resp_value;
				thread = resp_thread;
			end
		end
		assert (got)
		else
			abort_run($sformatf("no read response for register %0d within the timeout", reg_index));
	endtask

	task automatic apply_fault(input thread_idx_t fault_thread, input logic illegal,
		input logic violation, input logic unaligned_access, input scalar_t pc);
		fault_flags_t flags;
		flags = '{illegal_instr: illegal, access_violation: violation,
			unaligned: unaligned_access, pc: pc, thread: fault_thread, spare: 3'b000};
		@(posedge clk) fault_flags <= flags;
		@(posedge clk) fault_flags <= '0;
		// One edge in the encoder, one more into the registers
		repeat (2) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic reset_defaults();
		@(negedge clk);
		expect_equal("thread_enable", scalar_t'(thread_enable), 32'h1);
		expect_equal("interrupt_en", scalar_t'(interrupt_en), 32'h0);
		// Only thread 0 is enabled, so issue_thread must stay on it while free running
		repeat (4)
		begin
			expect_equal("resp_valid", scalar_t'(resp_valid), 32'h0);
			expect_equal("issue_valid", scalar_t'(issue_valid), 32'h1);
			expect_equal("issue_thread", scalar_t'(issue_thread), 32'h0);
			@(negedge clk);
		end
		@(posedge clk) stall <= 1'b1;
		@(negedge clk);
	endtask

	task automatic enable_rotation();
		scalar_t value;
		thread_mask_t mask;
		thread_idx_t expected;
		// Reset left issue_thread on thread 0 and stall has held it there since
		expected = '0;
		repeat (4)
		begin
			draw_bits(32, value);
			// An empty mask would lock out every later access
			if (value[3:0] == 4'h0)
				value[0] = 1'b1;
			mask = value[3:0];
			write_creg(CR_THREAD_ENABLE, value);
			expect_equal("thread_enable", scalar_t'(thread_enable), scalar_t'(mask));
			@(posedge clk) stall <= 1'b0;
			@(negedge clk);
			expect_equal("issue_thread", scalar_t'(issue_thread), scalar_t'(expected));
			repeat (8)
			begin
				@(negedge clk);
				expected = next_enabled(expected, mask);
				expect_equal("issue_thread", scalar_t'(issue_thread), scalar_t'(expected));
				expect_equal("issue_valid", scalar_t'(issue_valid), 32'h1);
			end
			// The edge that raises stall still sees it low and advances once more
			@(posedge clk) stall <= 1'b1;
			@(negedge clk);
			expected = next_enabled(expected, mask);
			expect_equal("issue_thread", scalar_t'(issue_thread), scalar_t'(expected));
			repeat (4)
			begin
				@(negedge clk);
				expect_equal("issue_thread", scalar_t'(issue_thread), scalar_t'(expected));
			end
		end
	endtask

	task automatic thread_id_reads();
		scalar_t value;
		thread_idx_t thread;
		int latency;
		write_creg(CR_THREAD_ENABLE, 32'hf);
		for (int t = 0; t < THREADS_PER_CORE; t++)
		begin
			steer_to_thread(thread_idx_t'(t));
			read_creg(CR_THREAD_ID, value, thread, latency);
			expect_equal("read latency", scalar_t'(latency), 32'd2);
			expect_equal("resp_thread", scalar_t'(thread), scalar_t'(t));
			expect_equal("resp_value", value, scalar_t'(int'(TB_CORE_ID) * THREADS_PER_CORE + t));
			// A read answers once and only once
			@(negedge clk);
			expect_equal("resp_valid", scalar_t'(resp_valid), 32'h0);
		end
	endtask

	task automatic fault_and_readback(input thread_idx_t fault_thread, input logic illegal,
		input logic violation, input logic unaligned_access, input scalar_t pc,
		inout thread_mask_t irq_model);
		scalar_t value;
		thread_idx_t thread;
		int latency;
		apply_fault(fault_thread, illegal, violation, unaligned_access, pc);
		irq_model[fault_thread] = 1'b0;
		expect_equal("interrupt_en", scalar_t'(interrupt_en), scalar_t'(irq_model));
		steer_to_thread(fault_thread);
		read_creg(CR_FAULT_REASON, value, thread, latency);
		expect_equal("resp_thread", scalar_t'(thread), scalar_t'(fault_thread));
		expect_equal("fault reason", value,
			scalar_t'(expected_reason(illegal, violation, unaligned_access)));
		read_creg(CR_FAULT_PC, value, thread, latency);
		expect_equal("fault pc", value, pc);
	endtask

	task automatic fault_capture();
		thread_mask_t irq_model;
		scalar_t value;
		thread_idx_t thread;
		int latency;
		irq_model = '0;
		for (int t = 0; t < THREADS_PER_CORE; t++)
		begin
			steer_to_thread(thread_idx_t'(t));
			write_creg(CR_INTERRUPT_ENABLE, '0);
			irq_model[t] = 1'b1;
			expect_equal("interrupt_en", scalar_t'(interrupt_en), scalar_t'(irq_model));
		end
		fault_and_readback(2'd2, 1'b1, 1'b0, 1'b1, 32'h0000_4a10, irq_model);
		fault_and_readback(2'd0, 1'b0, 1'b1, 1'b1, 32'h0000_81c4, irq_model);
		fault_and_readback(2'd3, 1'b1, 1'b1, 1'b1, 32'h0001_0f08, irq_model);
		// Thread 1 never faulted and keeps its reset state
		steer_to_thread(2'd1);
		read_creg(CR_FAULT_REASON, value, thread, latency);
		expect_equal("fault reason", value, scalar_t'(FR_NONE));
		read_creg(CR_FAULT_PC, value, thread, latency);
		expect_equal("fault pc", value, 32'h0);
	endtask

	task automatic halt_sequence();
		creg_access_t access;
		thread_idx_t held;
		write_creg(CR_THREAD_ENABLE, 32'hf);
		steer_to_thread(2'd2);
		write_creg(CR_HALT_THREAD, '0);
		expect_equal("thread_enable", scalar_t'(thread_enable), 32'hb);
		steer_to_thread(2'd0);
		write_creg(CR_HALT_THREAD, '0);
		expect_equal("thread_enable", scalar_t'(thread_enable), 32'ha);
		write_creg(CR_HALT, '0);
		expect_equal("thread_enable", scalar_t'(thread_enable), 32'h0);
		expect_equal("issue_valid", scalar_t'(issue_valid), 32'h0);
		// The last steer left issue_thread on thread 0
		held = 2'd0;
		// Stall is released so only the empty mask can keep issue_thread in place
		@(posedge clk) stall <= 1'b0;
		// With nothing enabled a read must stay silent for the whole window
		access = '{write_en: 1'b0, read_en: 1'b1, index: CR_THREAD_ID, write_val: '0};
		@(posedge clk) creg_access <= access;
		@(posedge clk) creg_access <= '0;
		repeat (SILENT_WINDOW)
		begin
			@(negedge clk);
			assert (resp_valid === 1'b0)
			else
				abort_run("a read produced a response while every thread was halted");
			expect_equal("issue_thread", scalar_t'(issue_thread), scalar_t'(held));
		end
		// Nor can a write bring the threads back
		write_creg(CR_THREAD_ENABLE, 32'hf);
		expect_equal("thread_enable", scalar_t'(thread_enable), 32'h0);
		expect_equal("issue_thread", scalar_t'(issue_thread), scalar_t'(held));
	endtask

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("simulation ran past its cycle limit before the tests finished");
	end

	initial
	begin
		reset = 1'b1;
		creg_access = '0;
		stall = 1'b0;
		fault_flags = '0;
		lfsr_state = LFSR_SEED;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		reset_defaults();
		enable_rotation();
		thread_id_reads();
		fault_capture();
		halt_sequence();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

/* files.f */
logic/core_types_pkg.sv
logic/creg_defs_pkg.sv
logic/pipe_stage.sv
logic/thread_select.sv
logic/fault_encoder.sv
logic/control_registers.sv
logic/creg_subsystem.sv
test/creg_subsystem_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status is the simulation result
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f files.f \
		--top-module creg_subsystem_tb -o creg_subsystem_sim \
	&& ./obj_dir/creg_subsystem_sim \
	|| { echo "build or simulation failed"; exit 1; }
